/* build.f */
+incdir+.
fetch_pkg.sv
ibus_if.sv
icache.sv
fetch_core.sv
fetch_status.sv
rv_fetch_top.sv
tb_rv_fetch.sv

/* build.sh */
#!/bin/sh
# Compile and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_rv_fetch -o tb_rv_fetch

output=$(./obj_dir/tb_rv_fetch)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^Finished with no errors$"; then
	exit 0
else
	exit 1
fi

/* fetch_core.sv */
/*
 Fetch core
 Holds the PC, fetches one word at a time, follows OP-IMM and JAL
 Any other opcode or a misaligned target halts with a sticky fault
*/

`default_nettype none

`include "fetch_settings.svh"

module fetch_core (
	input wire clock,
	input wire i_rst_n,
	ibus_if.requester bus,
	output logic o_retire,
	output logic o_fault_pulse,
	output logic [31:0] o_pc
);

	import fetch_pkg::*;

	// Core FSM states
	localparam logic [1:0] S_REQUEST = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_HALT = 2'd2;

	logic [1:0] state;
	logic [31:0] pc_q;
	logic request_q;

	// Decode of the returned word
	instr_word_u word;
	logic is_op_imm;
	logic is_jal;
	logic [31:0] jal_offset;
	logic [31:0] jal_target;
	logic target_misaligned;
	logic illegal;
	logic take_word;
	logic [31:0] next_pc;

	assign word = bus.rdata;

	assign is_op_imm = (word.i_fields.opcode == OPC_OP_IMM);
	assign is_jal = (word.j_fields.opcode == OPC_JAL);

	// J immediate, sign extended, bit 0 always zero
	assign jal_offset = {
		{12{word.j_fields.imm20}},
		word.j_fields.imm19_12,
		word.j_fields.imm11,
		word.j_fields.imm10_1,
		1'b0
	};
	assign jal_target = pc_q + jal_offset;

	// Only word targets are legal without compressed support
	assign target_misaligned = is_jal && jal_target[1];

	assign illegal = !(is_op_imm || is_jal) || target_misaligned;

	// Word accepted in the ready cycle
	assign take_word = (state == S_WAIT) && bus.ready;

	assign next_pc = is_jal ? jal_target : pc_q + 32'd4;

	// Fault flagged in the ready cycle itself
	assign o_fault_pulse = take_word && illegal;

	assign bus.request = request_q;
	assign bus.address = pc_q;
	assign o_pc = pc_q;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_REQUEST;
			pc_q <= `RESET_VECTOR;
			request_q <= 1'b0;
			o_retire <= 1'b0;
		end else begin
			o_retire <= 1'b0;
			case (state)
				S_REQUEST: begin
					// First request right after reset release
					request_q <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (take_word) begin
						if (illegal) begin
							// Stop fetching until reset
							request_q <= 1'b0;
							state <= S_HALT;
						end else begin
							// Request stays high with the new address
							pc_q <= next_pc;
							o_retire <= 1'b1;
						end
					end
				end
				S_HALT: begin
					request_q <= 1'b0;
				end
				default: begin
					request_q <= 1'b0;
					state <= S_HALT;
				end
			endcase
		end
	end

	// Address held while the bus has not answered
	a_address_stable: assert property (
		@(posedge clock) disable iff (!i_rst_n)
		(bus.request && !bus.ready) |=> $stable(bus.address)
	);

endmodule

`default_nettype wire

/* fetch_pkg.sv */
/*
 Fetch package
 RV32 opcode constants and the two decode views of one fetched word
*/

`default_nettype none

package fetch_pkg;

	// Major opcodes handled by the fetch front end
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// One instruction word, read as I-type or as J-type
	typedef union packed {
		// OP-IMM layout
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_fields;
		// JAL layout, immediate bits scattered
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fields;
	} instr_word_u;

endpackage

`default_nettype wire

/* fetch_settings.svh */
/*
 Fetch front end build settings
 Reset vector, instruction cache geometry and LED tap
*/

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// First fetch address after reset
`define RESET_VECTOR 32'h0000_0000

// One-word lines, power of two
`define ICACHE_LINES 32

// PC bit shown on the board LED
`define LED_BIT 6

`endif

/* fetch_status.sv */
/*
 Fetch status
 LED from a PC bit, sticky fault flag, retired instruction count
*/

`default_nettype none

`include "fetch_settings.svh"

module fetch_status (
	input wire clock,
	input wire i_rst_n,
	input wire i_retire,
	input wire i_fault_pulse,
	input wire [31:0] i_pc,
	output logic o_led,
	output logic o_fault,
	output logic [15:0] o_retired_count
);

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_led <= 1'b0;
			o_fault <= 1'b0;
			o_retired_count <= 16'd0;
		end else begin
			// Slow PC bit makes the LED blink
			o_led <= i_pc[`LED_BIT];

			// Held until the next reset
			if (i_fault_pulse) begin
				o_fault <= 1'b1;
			end

			// Free running, wraps at 16 bits
			if (i_retire) begin
				o_retired_count <= o_retired_count + 16'd1;
			end
		end
	end

	// Nothing retires once the core has halted
	a_count_frozen: assert property (
		@(posedge clock) disable iff (!i_rst_n)
		o_fault |=> $stable(o_retired_count)
	);

endmodule

`default_nettype wire

/* ibus_if.sv */
/*
 Instruction bus
 Level request with held address, single-cycle ready carrying rdata
*/

`default_nettype none

interface ibus_if;

	// Held high until ready is seen
	logic request;
	// One-cycle pulse, only while request is high
	logic ready;
	// Stable while request waits
	logic [31:0] address;
	// Valid in the ready cycle
	logic [31:0] rdata;

	// Core side
	modport requester (
		output request,
		output address,
		input ready,
		input rdata
	);

	// Cache or memory side
	modport responder (
		input request,
		input address,
		output ready,
		output rdata
	);

endinterface

`default_nettype wire

/* icache.sv */
/*
 Instruction cache
 Direct mapped, one word per line, refills from the external bus on a miss
*/

`default_nettype none

`include "fetch_settings.svh"

module icache (
	input wire clock,
	input wire i_rst_n,
	ibus_if.responder core,
	output logic o_mem_request,
	output logic [31:0] o_mem_address,
	input wire i_mem_ready,
	input wire [31:0] i_mem_rdata
);

	localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	// Cache FSM states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_MISS = 2'd1;
	localparam logic [1:0] S_RESP = 2'd2;

	logic [1:0] state;
	logic ready_q;
	logic [31:0] rdata_q;

	// Line storage
	logic [31:0] line_data [`ICACHE_LINES];
	logic [TAG_BITS-1:0] line_tag [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] line_valid;

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic hit;
	logic lookup;
	logic fill;

	// Word address split into index and tag
	assign index = core.address[INDEX_BITS+1:2];
	assign tag = core.address[31:INDEX_BITS+2];

	assign hit = line_valid[index] && (line_tag[index] == tag);

	// New core request looked up only from idle
	assign lookup = (state == S_IDLE) && core.request;
	// Refill word arrives from outside
	assign fill = (state == S_MISS) && i_mem_ready;

	// Core address is held by the requester for the whole miss
	assign o_mem_address = core.address;

	assign core.ready = ready_q;
	assign core.rdata = rdata_q;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
			ready_q <= 1'b0;
			o_mem_request <= 1'b0;
			line_valid <= '0;
		end else begin
			// Ready is a single-cycle pulse
			ready_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (lookup) begin
						if (hit) begin
							ready_q <= 1'b1;
							state <= S_RESP;
						end else begin
							// Forward the miss
							o_mem_request <= 1'b1;
							state <= S_MISS;
						end
					end
				end
				S_MISS: begin
					// Slow memory only stretches this state
					if (i_mem_ready) begin
						o_mem_request <= 1'b0;
						line_valid[index] <= 1'b1;
						ready_q <= 1'b1;
						state <= S_RESP;
					end
				end
				S_RESP: begin
					// Core still shows the old address here
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Response word and line writes
	always_ff @(posedge clock) begin
		if (lookup && hit) begin
			rdata_q <= line_data[index];
		end else if (fill) begin
			rdata_q <= i_mem_rdata;
			line_data[index] <= i_mem_rdata;
			line_tag[index] <= tag;
		end
	end

	// Ready to the core only answers a pending request
	a_ready_with_request: assert property (
		@(posedge clock) disable iff (!i_rst_n)
		core.ready |-> core.request
	);

endmodule

`default_nettype wire

/* rv_fetch_top.sv */
/*
 RV32 fetch front end top
 Core, instruction cache and status block on one external instruction bus
*/

`default_nettype none

module rv_fetch_top (
	input wire clock,
	input wire i_rst_n,
	output logic o_ibus_request,
	output logic [31:0] o_ibus_address,
	input wire i_ibus_ready,
	input wire [31:0] i_ibus_rdata,
	output logic o_led,
	output logic o_fault,
	output logic [15:0] o_retired_count
);

	// Core to status wires
	logic retire;
	logic fault_pulse;
	logic [31:0] pc;

	// Core to cache bus
	ibus_if core_bus ();

	icache icache_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.core(core_bus.responder),
		.o_mem_request(o_ibus_request),
		.o_mem_address(o_ibus_address),
		.i_mem_ready(i_ibus_ready),
		.i_mem_rdata(i_ibus_rdata)
	);

	fetch_core fetch_core_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.bus(core_bus.requester),
		.o_retire(retire),
		.o_fault_pulse(fault_pulse),
		.o_pc(pc)
	);

	fetch_status fetch_status_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_retire(retire),
		.i_fault_pulse(fault_pulse),
		.i_pc(pc),
		.o_led(o_led),
		.o_fault(o_fault),
		.o_retired_count(o_retired_count)
	);

endmodule

`default_nettype wire

/* tb_rv_fetch.sv */
/*
 Testbench for the RV32 fetch front end
 Random latency memory model, fetch model and checking assertions
*/

`default_nettype none

`include "fetch_settings.svh"

module tb_rv_fetch;

	// ADDI x0,x0,0 and JAL x0,-0x40
	localparam logic [31:0] NOP_WORD = 32'h0000_0013;
	localparam logic [31:0] JAL_BACK_WORD = 32'hFC1F_F06F;
	localparam logic [31:0] LAST_NOP_ADDR = 32'h0000_003C;
	localparam logic [31:0] JAL_ADDR = 32'h0000_0040;
	localparam logic [31:0] JUMP_BACK = 32'h0000_0040;
	// Never fetched, so the first phase sees no illegal word
	localparam logic [31:0] NO_FAULT_ADDR = 32'hFFFF_FFFC;
	localparam logic [31:0] FAULT_ADDR = 32'h0000_0020;
	// Words before the bad one all retire
	localparam logic [15:0] FAULT_RETIRES = FAULT_ADDR[17:2];
	localparam int LOOPS = 3;
	localparam int WORDS = 17;
	localparam logic [15:0] LOOP_RETIRES = 16'(LOOPS * WORDS);
	localparam int HALT_CYCLES = 20;
	// 3 loops x 17 words x 6 cycles plus the fault phase, wide margin
	localparam int CYCLE_LIMIT = 4000;

	// Word kinds of the program rule
	localparam int KIND_NOP = 0;
	localparam int KIND_JAL = 1;
	localparam int KIND_ILLEGAL = 2;

	logic clock = 1'b0;
	logic rst_n = 1'b0;
	logic ibus_request;
	logic [31:0] ibus_address;
	logic ibus_ready = 1'b0;
	logic [31:0] ibus_rdata = 32'h0;
	logic led;
	logic fault;
	logic [15:0] retired_count;

	// Core side bus, watched inside the DUT
	logic core_ready;
	logic [31:0] core_address;

	// Memory model state
	int seed = 89868;
	logic mem_busy = 1'b0;
	int delay_left = 0;
	logic [31:0] bad_addr = NO_FAULT_ADDR;

	// Fetch model state
	logic [31:0] exp_pc;
	logic [15:0] exp_retired;
	int loops_done;
	logic after_jal;
	logic fault_expected;
	logic exp_illegal;
	int ext_count;
	logic [31:0] last_ext_addr;
	logic ext_req_q;
	logic new_ext;

	int error_count = 0;
	int test_errors_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	string test_name = "reset";

	always #5 clock = ~clock;

	rv_fetch_top rv_fetch_top_inst (
		.clock(clock),
		.i_rst_n(rst_n),
		.o_ibus_request(ibus_request),
		.o_ibus_address(ibus_address),
		.i_ibus_ready(ibus_ready),
		.i_ibus_rdata(ibus_rdata),
		.o_led(led),
		.o_fault(fault),
		.o_retired_count(retired_count)
	);

	assign core_ready = rv_fetch_top_inst.core_bus.ready;
	assign core_address = rv_fetch_top_inst.core_bus.address;

	// Program rule, by address only
	function automatic int word_kind(input logic [31:0] addr, input logic [31:0] bad);
		if (addr == bad || addr[1:0] != 2'b00) begin
			return KIND_ILLEGAL;
		end
		if (addr <= LAST_NOP_ADDR) begin
			return KIND_NOP;
		end
		if (addr == JAL_ADDR) begin
			return KIND_JAL;
		end
		return KIND_ILLEGAL;
	endfunction

	function automatic logic [31:0] program_word(input logic [31:0] addr, input logic [31:0] bad);
		case (word_kind(addr, bad))
			KIND_NOP: return NOP_WORD;
			KIND_JAL: return JAL_BACK_WORD;
			default: return 32'h0;
		endcase
	endfunction

	task automatic count_mismatch(input string check, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count = error_count + 1;
		$display("error %s %s expected %h actual %h", test_name, check, expected, actual);
	endtask

	task automatic note_failure(input string what);
		error_count = error_count + 1;
		$display("%s failed: %s", test_name, what);
	endtask

	// Memory answers 1 to 4 cycles after the request
	always @(negedge clock) begin
		if (!rst_n) begin
			ibus_ready = 1'b0;
			mem_busy = 1'b0;
		end else if (ibus_ready) begin
			ibus_ready = 1'b0;
			mem_busy = 1'b0;
		end else if (ibus_request) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				delay_left = $unsigned($random(seed)) % 32'd4;
			end
			if (delay_left == 0) begin
				ibus_ready = 1'b1;
				ibus_rdata = program_word(ibus_address, bad_addr);
			end else begin
				delay_left = delay_left - 1;
			end
		end
	end

	// Rising external request marks a new refill
	assign new_ext = ibus_request && !ext_req_q;
	assign exp_illegal = (word_kind(exp_pc, bad_addr) == KIND_ILLEGAL);

	// Expected PC walk and retire count
	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			exp_pc <= `RESET_VECTOR;
			exp_retired <= 16'd0;
			loops_done <= 0;
			after_jal <= 1'b0;
			fault_expected <= 1'b0;
			ext_count <= 0;
			last_ext_addr <= 32'h0;
			ext_req_q <= 1'b0;
		end else begin
			ext_req_q <= ibus_request;
			if (new_ext) begin
				ext_count <= ext_count + 1;
				last_ext_addr <= ibus_address;
			end
			if (core_ready && !fault_expected) begin
				case (word_kind(exp_pc, bad_addr))
					KIND_NOP: begin
						exp_pc <= exp_pc + 32'd4;
						exp_retired <= exp_retired + 16'd1;
						after_jal <= 1'b0;
					end
					KIND_JAL: begin
						exp_pc <= exp_pc - JUMP_BACK;
						exp_retired <= exp_retired + 16'd1;
						loops_done <= loops_done + 1;
						after_jal <= 1'b1;
					end
					default: begin
						fault_expected <= 1'b1;
					end
				endcase
			end
		end
	end

	// Quiet outputs at the first edge after release
	a_reset_state: assert property (@(posedge clock)
		$rose(rst_n) |-> (!ibus_request && !fault && retired_count == 16'd0)
	) else count_mismatch("reset state", 32'h0,
		{14'h0, $sampled(ibus_request), $sampled(fault), $sampled(retired_count)});

	a_first_address: assert property (@(posedge clock) disable iff (!rst_n)
		(new_ext && ext_count == 0) |-> ibus_address == `RESET_VECTOR
	) else count_mismatch("first address", `RESET_VECTOR, $sampled(ibus_address));

	a_address_step: assert property (@(posedge clock) disable iff (!rst_n)
		(new_ext && ext_count != 0) |-> ibus_address == last_ext_addr + 32'd4
	) else count_mismatch("address step", $sampled(last_ext_addr) + 32'd4,
		$sampled(ibus_address));

	// Whole program fits in the cache
	a_no_refill: assert property (@(posedge clock) disable iff (!rst_n)
		new_ext |-> loops_done == 0
	) else note_failure("external request after the first loop");

	a_fetch_order: assert property (@(posedge clock) disable iff (!rst_n)
		core_ready |-> core_address == exp_pc
	) else count_mismatch("core address", $sampled(exp_pc), $sampled(core_address));

	a_jal_redirect: assert property (@(posedge clock) disable iff (!rst_n)
		(core_ready && after_jal) |-> core_address == 32'h0
	) else count_mismatch("jump target", 32'h0, $sampled(core_address));

	// Count settles before the next word arrives
	a_retire_count: assert property (@(posedge clock) disable iff (!rst_n)
		core_ready |-> retired_count == exp_retired
	) else count_mismatch("retired count", {16'h0, $sampled(exp_retired)},
		{16'h0, $sampled(retired_count)});

	a_led: assert property (@(posedge clock) disable iff (!rst_n)
		core_ready |-> led == exp_pc[`LED_BIT]
	) else count_mismatch("led", {31'h0, $sampled(exp_pc[`LED_BIT])}, {31'h0, $sampled(led)});

	a_fault_rise: assert property (@(posedge clock) disable iff (!rst_n)
		(core_ready && exp_illegal) |=> fault
	) else count_mismatch("fault flag", 32'h1, {31'h0, $sampled(fault)});

	a_no_fault: assert property (@(posedge clock) disable iff (!rst_n)
		!fault_expected |-> !fault
	) else note_failure("fault raised on a legal word");

	a_halt_request: assert property (@(posedge clock) disable iff (!rst_n)
		fault_expected |-> !ibus_request
	) else note_failure("external request after the fault");

	a_count_frozen: assert property (@(posedge clock) disable iff (!rst_n)
		fault_expected |-> retired_count == FAULT_RETIRES
	) else count_mismatch("frozen count", {16'h0, FAULT_RETIRES},
		{16'h0, $sampled(retired_count)});

	// Hang guard
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout in test %s after %0d cycles", test_name, cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic apply_reset(input logic [31:0] bad);
		@(negedge clock);
		rst_n = 1'b0;
		bad_addr = bad;
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_start = error_count;
	endtask

	task automatic finish_test;
		int errors;
		errors = error_count - test_errors_start;
		tests_run = tests_run + 1;
		if (errors > 0) begin
			tests_failed = tests_failed + 1;
		end
		$display("test %s done: %0d errors", test_name, errors);
	endtask

	initial begin
		rst_n = 1'b0;
		// Clean program, run until the word after the last jump
		start_test("loop_fetch");
		apply_reset(NO_FAULT_ADDR);
		while (exp_retired <= LOOP_RETIRES) begin
			@(negedge clock);
		end
		finish_test();

		// Illegal word at the fault address halts the core
		start_test("fault_halt");
		apply_reset(FAULT_ADDR);
		while (!fault) begin
			@(negedge clock);
		end
		repeat (HALT_CYCLES) @(negedge clock);
		finish_test();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
